/* vlog.f */
decodePkg.sv
opcodeLatch.sv
tStateSequencer.sv
loadMoveDecoder.sv
aluOpDecoder.sv
instructionDecoder.sv
controlRegister.sv
decodeUnit.sv
decodeChecker.sv
tbDecodeUnit.sv

/* Bender.yml */
package:
  name: decode_unit

sources:
  - decodePkg.sv
  - opcodeLatch.sv
  - tStateSequencer.sv
  - loadMoveDecoder.sv
  - aluOpDecoder.sv
  - instructionDecoder.sv
  - controlRegister.sv
  - decodeUnit.sv
  - target: test
    files:
      - decodeChecker.sv
      - tbDecodeUnit.sv

/* tbDecodeUnit.sv */
// sends 400 opcodes one at a time, each only after the previous fetchNext; the last 100 are ALU ops
`timescale 1ns/10ps

module tbDecodeUnit;

    logic        CLK, reset, opcodeValid;
    logic [7:0]  opcode;
    logic        busy, fetchNext, operandFetch, regWrite, selectIndexLow, selectIndexHigh;
    logic        useIy, aluStart, invertIn, writeAccumulator;
    logic [2:0]  regDest, regSource, aluOp;
    logic [31:0] lfsrState, idleDraw;
    int          errorCount, opcodeCount, timeoutCount;

    decodeUnit u_decodeUnit (.*);

    decodeChecker u_checker (.*);

    always #10 CLK = ~CLK;

    function automatic logic [31:0] nextLfsr(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    // one LFSR step per bit, each new bit shifted in at the bottom
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = nextLfsr(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic logic [7:0] pickOpcode(input int index);
        logic [31:0] draw;
        if (index >= 300) begin
            draw = takeBits(6);
            return {2'b10, draw[5:0]};
        end
        draw = takeBits(3);
        if (draw[2:0] == 3'd0) begin  // roughly one byte in eight becomes a prefix
            draw = takeBits(1);
            return draw[0] ? 8'hFD : 8'hDD;
        end
        draw = takeBits(8);
        return draw[7:0];
    endfunction

    task automatic waitFetchNext();
        int cycles;
        cycles = 0;
        do begin
            @(posedge CLK);
            cycles++;
        end while (!fetchNext && cycles < 20);
        if (!fetchNext) begin
            $display("timed out after %0d cycles waiting for fetchNext", cycles);
            timeoutCount++;
        end
    endtask

    initial begin
        CLK = 1'b0;
        reset = 1'b1;
        opcodeValid = 1'b0;
        opcode = 8'h00;
        lfsrState = 32'h6422;
        timeoutCount = 0;
        repeat (8) @(posedge CLK);
        reset <= 1'b0;
        @(posedge CLK);
        for (int sent = 0; sent < 400 && timeoutCount == 0; sent++) begin
            idleDraw = takeBits(2);
            repeat (idleDraw[1:0]) @(posedge CLK);
            opcodeValid <= 1'b1;
            opcode <= pickOpcode(sent);
            @(posedge CLK);
            opcodeValid <= 1'b0;
            waitFetchNext();
        end
        repeat (3) @(posedge CLK);
        @(negedge CLK);  // let the checker finish the last edge
        $display("errors %0d, timeouts %0d, opcodes checked %0d",
                 errorCount, timeoutCount, opcodeCount);
        if (opcodeCount != 400) begin
            $display("only %0d of 400 opcodes reached the checker", opcodeCount);
        end
        if (errorCount == 0 && timeoutCount == 0 && opcodeCount == 400) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* decodeChecker.sv */
// cycle model of the decode unit; assumes one instruction in flight and compares outputs one edge late
`timescale 1ns/10ps

module decodeChecker import decodePkg::*; (
    input  logic       CLK,
    input  logic       reset,
    input  logic       opcodeValid,
    input  logic [7:0] opcode,
    input  logic       busy,
    input  logic       fetchNext,
    input  logic       operandFetch,
    input  logic       regWrite,
    input  logic [2:0] regDest,
    input  logic [2:0] regSource,
    input  logic       selectIndexLow,
    input  logic       selectIndexHigh,
    input  logic       useIy,
    input  logic       aluStart,
    input  logic [2:0] aluOp,
    input  logic       invertIn,
    input  logic       writeAccumulator,
    output int         errorCount,
    output int         opcodeCount
);

    logic [7:0] modelOpcode;
    logic       modelBusy, modelIndex, modelIy;
    int         modelStep;  // 1 for T1, 0 while idle
    logic [2:0] y, z;
    logic       inT2, inT3, isLoad, isMove, isAlu;
    logic       expBusy, expFetch, expOperand, expRegWrite, expLow, expHigh, expUseIy;
    logic       expAluStart, expInvert, expWriteAcc;
    logic [2:0] expDest, expSource, expAluOp;

    task automatic checkValue(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            $display("Error %s expected %h actual %h at %0t", name, expected, actual, $time);
            errorCount++;
        end
    endtask

    always @(posedge CLK) begin
        if (reset) begin
            modelOpcode = 8'h00;
            modelBusy = 1'b0;
            modelStep = 0;
            modelIndex = 1'b0;
            modelIy = 1'b0;
            errorCount = 0;
            opcodeCount = 0;
        end else begin
            checkValue("busy", expBusy, busy);
            checkValue("fetchNext", expFetch, fetchNext);
            checkValue("operandFetch", expOperand, operandFetch);
            checkValue("regWrite", expRegWrite, regWrite);
            checkValue("regDest", expDest, regDest);
            checkValue("regSource", expSource, regSource);
            checkValue("selectIndexLow", expLow, selectIndexLow);
            checkValue("selectIndexHigh", expHigh, selectIndexHigh);
            checkValue("useIy", expUseIy, useIy);
            checkValue("aluStart", expAluStart, aluStart);
            checkValue("aluOp", expAluOp, aluOp);
            checkValue("invertIn", expInvert, invertIn);
            checkValue("writeAccumulator", expWriteAcc, writeAccumulator);
        end
        // strobes that appear after this edge belong to the T-state the model is in now
        y = modelOpcode[5:3];
        z = modelOpcode[2:0];
        inT2 = modelBusy && (modelStep == 2);
        inT3 = modelBusy && (modelStep == 3);
        isLoad = (modelOpcode[7:6] == 2'b00) && (z == REG_MEM);
        isMove = modelOpcode[7:6] == 2'b01;
        isAlu = modelOpcode[7:6] == 2'b10;
        expOperand = inT2 && isLoad;
        expRegWrite = (inT3 && isLoad) || (inT2 && isMove);
        expDest = expRegWrite ? y : 3'd0;
        expSource = (inT2 && (isMove || isAlu)) ? z : 3'd0;
        expHigh = inT2 && isMove && modelIndex && ((y == REG_H) || (z == REG_H));
        expLow = inT2 && isMove && modelIndex && ((y == REG_L) || (z == REG_L));
        expUseIy = modelIy && (expHigh || expLow);
        expAluStart = inT2 && isAlu;
        expAluOp = expAluStart ? y : 3'd0;
        expInvert = expAluStart && ((y == ALU_SUB) || (y == ALU_SBC) || (y == ALU_CP));
        expWriteAcc = inT3 && isAlu && (y != ALU_CP);  // compare never writes back
        expFetch = inT3 ? (isLoad || isAlu) : (inT2 && !isLoad && !isAlu);
        if (!reset && opcodeValid) begin
            modelOpcode = opcode;
            modelBusy = 1'b1;
            modelStep = 1;
            opcodeCount++;
        end else if (expFetch) begin
            // a prefix arms the index state, anything else clears it
            modelBusy = 1'b0;
            modelStep = 0;
            modelIndex = (modelOpcode == PREFIX_IX) || (modelOpcode == PREFIX_IY);
            modelIy = modelOpcode == PREFIX_IY;
        end else if (modelBusy) begin
            modelStep++;
        end
        expBusy = modelBusy;
    end

endmodule

/* decodeUnit.sv */
// outputs trail the T-state by one cycle; opcodeValid must stay low while busy is high
`timescale 1ns/10ps

module decodeUnit import decodePkg::*; (
    input  logic       CLK,
    input  logic       reset,
    input  logic       opcodeValid,
    input  logic [7:0] opcode,
    output logic       busy,
    output logic       fetchNext,
    output logic       operandFetch,
    output logic       regWrite,
    output logic [2:0] regDest,
    output logic [2:0] regSource,
    output logic       selectIndexLow,
    output logic       selectIndexHigh,
    output logic       useIy,
    output logic       aluStart,
    output logic [2:0] aluOp,
    output logic       invertIn,
    output logic       writeAccumulator
);

    opcodeWord           latchedOpcode;
    logic                indexActive;
    logic                indexIsIy;
    logic [T_STATES-1:0] xpt;
    logic                endState;
    logic                decOperandFetch;
    logic                decRegWrite;
    logic [2:0]          decRegDest;
    logic [2:0]          decRegSource;
    logic                decSelectIndexLow;
    logic                decSelectIndexHigh;
    logic                decAluStart;
    logic [2:0]          decAluOp;
    logic                decInvertIn;
    logic                decWriteAccumulator;

    opcodeLatch u_opcodeLatch (
        .CLK(CLK),
        .reset(reset),
        .opcodeValid(opcodeValid),
        .opcodeIn(opcode),
        .endState(endState),
        .opcode(latchedOpcode),
        .indexActive(indexActive),
        .indexIsIy(indexIsIy)
    );

    tStateSequencer u_tStateSequencer (
        .CLK(CLK),
        .reset(reset),
        .opcodeValid(opcodeValid),
        .endState(endState),
        .xpt(xpt),
        .busy(busy)
    );

    instructionDecoder u_instructionDecoder (
        .xpt(xpt),
        .opcode(latchedOpcode),
        .indexActive(indexActive),
        .endState(endState),
        .operandFetch(decOperandFetch),
        .regWrite(decRegWrite),
        .regDest(decRegDest),
        .regSource(decRegSource),
        .selectIndexLow(decSelectIndexLow),
        .selectIndexHigh(decSelectIndexHigh),
        .aluStart(decAluStart),
        .aluOp(decAluOp),
        .invertIn(decInvertIn),
        .writeAccumulator(decWriteAccumulator)
    );

    controlRegister u_controlRegister (
        .CLK(CLK),
        .reset(reset),
        .busy(busy),
        .endState(endState),
        .decOperandFetch(decOperandFetch),
        .decRegWrite(decRegWrite),
        .decRegDest(decRegDest),
        .decRegSource(decRegSource),
        .decSelectIndexLow(decSelectIndexLow),
        .decSelectIndexHigh(decSelectIndexHigh),
        .decAluStart(decAluStart),
        .decAluOp(decAluOp),
        .decInvertIn(decInvertIn),
        .decWriteAccumulator(decWriteAccumulator),
        .indexIsIy(indexIsIy),
        .fetchNext(fetchNext),
        .operandFetch(operandFetch),
        .regWrite(regWrite),
        .regDest(regDest),
        .regSource(regSource),
        .selectIndexLow(selectIndexLow),
        .selectIndexHigh(selectIndexHigh),
        .useIy(useIy),
        .aluStart(aluStart),
        .aluOp(aluOp),
        .invertIn(invertIn),
        .writeAccumulator(writeAccumulator)
    );

endmodule

/* controlRegister.sv */
// every strobe is delayed one cycle and forced low while the sequencer is idle
`timescale 1ns/10ps

module controlRegister (
    input  logic       CLK,
    input  logic       reset,
    input  logic       busy,
    input  logic       endState,
    input  logic       decOperandFetch,
    input  logic       decRegWrite,
    input  logic [2:0] decRegDest,
    input  logic [2:0] decRegSource,
    input  logic       decSelectIndexLow,
    input  logic       decSelectIndexHigh,
    input  logic       decAluStart,
    input  logic [2:0] decAluOp,
    input  logic       decInvertIn,
    input  logic       decWriteAccumulator,
    input  logic       indexIsIy,
    output logic       fetchNext,
    output logic       operandFetch,
    output logic       regWrite,
    output logic [2:0] regDest,
    output logic [2:0] regSource,
    output logic       selectIndexLow,
    output logic       selectIndexHigh,
    output logic       useIy,
    output logic       aluStart,
    output logic [2:0] aluOp,
    output logic       invertIn,
    output logic       writeAccumulator
);

    always_ff @(posedge CLK) begin
        if (reset) begin
            fetchNext <= 1'b0;
            operandFetch <= 1'b0;
            regWrite <= 1'b0;
            regDest <= 3'd0;
            regSource <= 3'd0;
            selectIndexLow <= 1'b0;
            selectIndexHigh <= 1'b0;
            useIy <= 1'b0;
            aluStart <= 1'b0;
            aluOp <= 3'd0;
            invertIn <= 1'b0;
            writeAccumulator <= 1'b0;
        end else begin
            fetchNext <= busy && endState;  // single end-of-instruction pulse
            operandFetch <= busy && decOperandFetch;
            regWrite <= busy && decRegWrite;
            regDest <= busy ? decRegDest : 3'd0;
            regSource <= busy ? decRegSource : 3'd0;
            selectIndexLow <= busy && decSelectIndexLow;
            selectIndexHigh <= busy && decSelectIndexHigh;
            useIy <= busy && indexIsIy && (decSelectIndexLow || decSelectIndexHigh);
            aluStart <= busy && decAluStart;
            aluOp <= busy ? decAluOp : 3'd0;
            invertIn <= busy && decInvertIn;
            writeAccumulator <= busy && decWriteAccumulator;
        end
    end

    // the two leaves own these strobes, so both high means the split went wrong
    assert property (@(posedge CLK) disable iff (reset) !(writeAccumulator && regWrite))
    else $error("writeAccumulator and regWrite asserted together");

endmodule

/* instructionDecoder.sv */
// purely combinational; exactly one leaf is enabled, so the OR merge never sees two drivers active
`timescale 1ns/10ps

module instructionDecoder import decodePkg::*; (
    input  logic [T_STATES-1:0] xpt,
    input  opcodeWord           opcode,
    input  logic                indexActive,
    output logic                endState,
    output logic                operandFetch,
    output logic                regWrite,
    output logic [2:0]          regDest,
    output logic [2:0]          regSource,
    output logic                selectIndexLow,
    output logic                selectIndexHigh,
    output logic                aluStart,
    output logic [2:0]          aluOp,
    output logic                invertIn,
    output logic                writeAccumulator
);

    logic       loadMoveEnd;
    logic       aluEnd;
    logic [2:0] loadMoveSource;
    logic [2:0] aluSource;

    loadMoveDecoder u_loadMoveDecoder (
        .enable(!opcode.raw[7]),  // lower half of the table
        .xpt(xpt),
        .opcode(opcode),
        .indexActive(indexActive),
        .endState(loadMoveEnd),
        .operandFetch(operandFetch),
        .regWrite(regWrite),
        .regDest(regDest),
        .regSource(loadMoveSource),
        .selectIndexLow(selectIndexLow),
        .selectIndexHigh(selectIndexHigh)
    );

    aluOpDecoder u_aluOpDecoder (
        .enable(opcode.raw[7]),
        .xpt(xpt),
        .opcode(opcode),
        .endState(aluEnd),
        .aluStart(aluStart),
        .aluOp(aluOp),
        .regSource(aluSource),
        .invertIn(invertIn),
        .writeAccumulator(writeAccumulator)
    );

    assign endState = loadMoveEnd | aluEnd;
    assign regSource = loadMoveSource | aluSource;

endmodule

/* aluOpDecoder.sv */
// covers the x=1x half of the table; x=11 bytes, prefixes included, decode as two-state no-ops
`timescale 1ns/10ps

module aluOpDecoder import decodePkg::*; (
    input  logic                enable,
    input  logic [T_STATES-1:0] xpt,
    input  opcodeWord           opcode,
    output logic                endState,
    output logic                aluStart,
    output logic [2:0]          aluOp,
    output logic [2:0]          regSource,
    output logic                invertIn,
    output logic                writeAccumulator
);

    logic isAlu;
    logic isMisc;
    logic needsInvert;

    assign isAlu  = enable && (opcode.f.x == X_ALU);
    assign isMisc = enable && (opcode.f.x == X_MISC);

    assign needsInvert = (opcode.f.y == ALU_SUB) || (opcode.f.y == ALU_SBC) ||
                         (opcode.f.y == ALU_CP);

    // operand goes to the ALU in T2, the result lands in T3
    assign aluStart = isAlu && xpt[T2];
    assign aluOp = aluStart ? opcode.f.y : 3'd0;
    assign regSource = aluStart ? opcode.f.z : 3'd0;
    assign invertIn = aluStart && needsInvert;

    assign writeAccumulator = isAlu && xpt[T3] && (opcode.f.y != ALU_CP);  // compare only sets flags

    assign endState = (isAlu && xpt[T3]) || (isMisc && xpt[T2]);

endmodule

/* loadMoveDecoder.sv */
// index selects only replace H and L in register moves; immediate loads ignore the prefix
`timescale 1ns/10ps

module loadMoveDecoder import decodePkg::*; (
    input  logic                enable,
    input  logic [T_STATES-1:0] xpt,
    input  opcodeWord           opcode,
    input  logic                indexActive,
    output logic                endState,
    output logic                operandFetch,
    output logic                regWrite,
    output logic [2:0]          regDest,
    output logic [2:0]          regSource,
    output logic                selectIndexLow,
    output logic                selectIndexHigh
);

    logic isLoadImm;
    logic isMove;
    logic isOther;
    logic loadWrite;
    logic moveWrite;
    logic indexMove;

    // group selection on the field view
    assign isLoadImm = enable && (opcode.f.x == X_LOAD) && (opcode.f.z == REG_MEM);
    assign isOther   = enable && (opcode.f.x == X_LOAD) && (opcode.f.z != REG_MEM);
    assign isMove    = enable && (opcode.f.x == X_MOVE);

    assign loadWrite = isLoadImm && xpt[T3];  // immediate byte is written back in T3
    assign moveWrite = isMove && xpt[T2];

    assign operandFetch = isLoadImm && xpt[T2];
    assign regWrite = loadWrite || moveWrite;
    assign regDest = regWrite ? opcode.f.y : 3'd0;
    assign regSource = moveWrite ? opcode.f.z : 3'd0;

    assign endState = loadWrite || ((isMove || isOther) && xpt[T2]);

    // either operand of a move can be redirected to the index register halves
    assign indexMove = moveWrite && indexActive;

    assign selectIndexHigh = indexMove && ((opcode.f.y == REG_H) || (opcode.f.z == REG_H));
    assign selectIndexLow  = indexMove && ((opcode.f.y == REG_L) || (opcode.f.z == REG_L));

endmodule

/* tStateSequencer.sv */
// instructions run at most four T-states; the sequencer waits for the decoder to signal the end
`timescale 1ns/10ps

module tStateSequencer import decodePkg::*; (
    input  logic                CLK,
    input  logic                reset,
    input  logic                opcodeValid,
    input  logic                endState,
    output logic [T_STATES-1:0] xpt,
    output logic                busy
);

    always_ff @(posedge CLK) begin
        if (reset) begin
            xpt <= '0;
            busy <= 1'b0;
        end else if (opcodeValid) begin
            xpt <= '0;
            xpt[T1] <= 1'b1;  // a new opcode always starts in T1
            busy <= 1'b1;
        end else if (endState) begin
            xpt <= '0;
            busy <= 1'b0;
        end else if (busy) begin
            xpt <= {xpt[T_STATES-2:0], xpt[T_STATES-1]};
        end
    end

    assert property (@(posedge CLK) disable iff (reset)
        busy ? $onehot(xpt) : (xpt == '0))
    else $error("xpt is not one-hot while busy or not clear while idle");

endmodule

/* opcodeLatch.sv */
// no back-pressure; opcodeValid while an instruction runs is illegal and is only caught by assertion
`timescale 1ns/10ps

module opcodeLatch import decodePkg::*; (
    input  logic       CLK,
    input  logic       reset,
    input  logic       opcodeValid,
    input  logic [7:0] opcodeIn,
    input  logic       endState,
    output opcodeWord  opcode,
    output logic       indexActive,
    output logic       indexIsIy
);

    logic isPrefix;

    assign isPrefix = (opcode.raw == PREFIX_IX) || (opcode.raw == PREFIX_IY);

    always_ff @(posedge CLK) begin
        if (opcodeValid) begin
            opcode.raw <= opcodeIn;
        end
    end

    // a prefix arms the index state when it ends, any other opcode clears it when it ends
    always_ff @(posedge CLK) begin
        if (reset) begin
            indexActive <= 1'b0;
            indexIsIy <= 1'b0;
        end else if (endState) begin
            indexActive <= isPrefix;
            indexIsIy <= (opcode.raw == PREFIX_IY);
        end
    end

    // once an opcode is taken no new one may come until its last T-state has passed
    assert property (@(posedge CLK) disable iff (reset)
        opcodeValid |=> (!opcodeValid until_with endState))
    else $error("opcodeValid arrived while an instruction was in progress");

endmodule

/* decodePkg.sv */
// opcode fields follow the usual x/y/z split of an 8-bit CPU byte; only DD and FD count as prefixes
package decodePkg;

    // field view of the opcode byte, x in the top two bits
    typedef struct packed {
        logic [1:0] x;
        logic [2:0] y;  // destination register or ALU operation
        logic [2:0] z;  // source register
    } opcodeFields;

    // one byte, read either whole or by its fields
    typedef union packed {
        logic [7:0]  raw;
        opcodeFields f;
    } opcodeWord;

    // T-state bit positions inside the one-hot xpt word
    localparam int T_STATES = 4;
    localparam int T1 = 0;
    localparam int T2 = 1;
    localparam int T3 = 2;
    localparam int T4 = 3;

    // instruction groups selected by the x field
    localparam logic [1:0] X_LOAD = 2'b00;
    localparam logic [1:0] X_MOVE = 2'b01;
    localparam logic [1:0] X_ALU  = 2'b10;
    localparam logic [1:0] X_MISC = 2'b11;

    localparam logic [7:0] PREFIX_IX = 8'hDD;
    localparam logic [7:0] PREFIX_IY = 8'hFD;

    localparam logic [2:0] REG_H   = 3'd4;
    localparam logic [2:0] REG_L   = 3'd5;
    localparam logic [2:0] REG_MEM = 3'd6;  // also marks the immediate load in the x=00 group

    // these operations feed the ALU the inverted operand
    localparam logic [2:0] ALU_SUB = 3'd2;
    localparam logic [2:0] ALU_SBC = 3'd3;
    localparam logic [2:0] ALU_CP  = 3'd7;

endpackage
